//--- perfect_memory.f
verilog/perfect_mem_pkg.sv
verilog/mem_req_decode.sv
verilog/access_timer.sv
verilog/mem_line_store.sv
verilog/load_align.sv
verilog/perfect_memory.sv
test/perfect_memory_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log for the pass line
set -e

cd "$(dirname "$0")"

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    --top-module perfect_memory_tb \
    -f perfect_memory.f \
    -Mdir "$OBJ" -o Vperfect_memory_tb

"./$OBJ/Vperfect_memory_tb" | tee "$LOG"

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi

//--- test/perfect_memory_tb.sv
// testbench for the simulation memory, LINES 64 and DELAY 3
// every line is written once before any load is checked, since storage starts undefined

module perfect_memory_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import perfect_mem_pkg::*;

    localparam int LINES   = 64;
    localparam int DELAY   = 3;
    localparam int SPAN    = LINES * LINE_BYTES;
    localparam int TIMEOUT = 50;

    logic  clk_i;
    logic  rstn_i;
    logic  valid_i;
    logic  wr_ena_i;
    logic  ready_o;
    addr_t addr_i;
    data_t wr_data_i;
    data_t rdata_o;
    size_e word_size_i;

    // byte-wide reference image of the whole memory
    logic [7:0] shadow [SPAN];
    int         errors;
    int         checks;

    perfect_memory #(
        .LINES (LINES),
        .DELAY (DELAY)
    ) dut (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .addr_i      (addr_i),
        .valid_i     (valid_i),
        .wr_ena_i    (wr_ena_i),
        .wr_data_i   (wr_data_i),
        .word_size_i (word_size_i),
        .rdata_o     (rdata_o),
        .ready_o     (ready_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #10 clk_i = ~clk_i;
        end
    end

    function automatic data_t random_data();
        return {$urandom(), $urandom()};
    endfunction

    // line wraps modulo the depth, offset aligned down to the access size
    function automatic int shadow_index(addr_t addr, int nbytes, int i);
        int line;
        int ofs;
        line = int'((addr >> OFS_W) % LINES);
        ofs  = int'(addr[OFS_W-1:0]) & ~(nbytes - 1);
        return line * LINE_BYTES + ofs + i;
    endfunction

    function automatic data_t predict_load(addr_t addr, logic [3:0] code);
        int    n;
        data_t raw;
        n   = 1 << code[1:0];
        raw = '0;
        if (code > 4'd6) begin
            return '0;
        end
        for (int i = 0; i < n; i++) begin
            raw[i*8 +: 8] = shadow[shadow_index(addr, n, i)];
        end
        // signed byte, half and word
        if (code <= 4'd2 && raw[n*8-1]) begin
            raw = raw | (~64'd0 << (n * 8));
        end
        return raw;
    endfunction

    function automatic void apply_store(addr_t addr, logic [3:0] code, data_t data);
        int n;
        n = 1 << code[1:0];
        if (code <= 4'd3) begin
            for (int i = 0; i < n; i++) begin
                shadow[shadow_index(addr, n, i)] = data[i*8 +: 8];
            end
        end
    endfunction

    task automatic check_data(string name, data_t expected, data_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic stop_on_timeout(string what);
        $display("timeout: %s", what);
        $display("errors: %0d of %0d checks", errors, checks);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (!ready_o) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_on_timeout("ready_o stayed low before a request");
            end
            @(negedge clk_i);
        end
    endtask

    // poke keeps valid_i high one more edge with a conflicting store
    task automatic send_request(string name, logic wr, addr_t addr, logic [3:0] code,
                                data_t data, logic check_rd, logic poke);
        data_t expected;
        int    busy;
        expected = predict_load(addr, code);
        wait_ready();
        @(posedge clk_i);
        valid_i     <= 1'b1;
        wr_ena_i    <= wr;
        addr_i      <= addr;
        word_size_i <= size_e'(code);
        wr_data_i   <= data;
        @(posedge clk_i);
        if (poke) begin
            wr_ena_i    <= 1'b1;
            word_size_i <= SZ_D;
            wr_data_i   <= ~data;
        end else begin
            valid_i <= 1'b0;
        end
        if (wr) begin
            apply_store(addr, code, data);
        end
        busy = 0;
        @(negedge clk_i);
        while (!ready_o) begin
            busy++;
            if (busy > TIMEOUT) begin
                stop_on_timeout("ready_o stayed low after an accepted request");
            end
            if (check_rd) begin
                check_data(name, expected, rdata_o);
            end
            @(posedge clk_i);
            valid_i <= 1'b0;
            @(negedge clk_i);
        end
        checks++;
        assert (busy == DELAY) else begin
            errors++;
            $display("Fail %s busy cycles: expected %0d, actual %0d", name, DELAY, busy);
        end
        if (check_rd) begin
            check_data(name, expected, rdata_o);
        end
    endtask

    task automatic read_line(string name, addr_t addr);
        send_request(name, 1'b0, addr & ~addr_t'(15), 4'd3, '0, 1'b1, 1'b0);
        send_request(name, 1'b0, (addr & ~addr_t'(15)) | 8, 4'd3, '0, 1'b1, 1'b0);
    endtask

    initial begin
        addr_t      a;
        data_t      d;
        logic [3:0] code;
        void'($urandom(32'h3e2c));
        errors      = 0;
        checks      = 0;
        valid_i     = 1'b0;
        wr_ena_i    = 1'b0;
        addr_i      = '0;
        wr_data_i   = '0;
        word_size_i = SZ_B;
        rstn_i      = 1'b0;
        repeat (16) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(negedge clk_i);
        check_data("reset ready_o", 64'd1, data_t'(ready_o));
        check_data("reset rdata_o", '0, rdata_o);

        // fill every line, upper address bits random to exercise the wrap
        for (int l = 0; l < LINES; l++) begin
            for (int h = 0; h < 2; h++) begin
                a       = addr_t'($urandom());
                a[9:0]  = 10'(l * LINE_BYTES + h * 8);
                send_request("fill", 1'b1, a, 4'd3, random_data(), 1'b0, 1'b0);
            end
        end

        for (int i = 0; i < 20; i++) begin
            a = addr_t'($urandom());
            d = random_data();
            send_request("double store", 1'b1, a, 4'd3, d, 1'b1, 1'b0);
            send_request("double load", 1'b0, a, 4'd3, '0, 1'b1, 1'b0);
            check_data("double readback", d, rdata_o);
        end

        for (int i = 0; i < 40; i++) begin
            a    = addr_t'($urandom());
            code = 4'(i % 3);
            send_request("narrow store", 1'b1, a, code, random_data(), 1'b1, 1'b0);
            read_line("narrow neighbours", a);
        end

        for (int i = 0; i < 70; i++) begin
            send_request("extend load", 1'b0, addr_t'($urandom()), 4'(i % 7), '0,
                         1'b1, 1'b0);
        end

        for (int c = 7; c < 16; c++) begin
            send_request("invalid load", 1'b0, addr_t'($urandom()), 4'(c), '0, 1'b1, 1'b0);
        end
        for (int c = 4; c < 16; c++) begin
            a = addr_t'($urandom());
            send_request("ignored store", 1'b1, a, 4'(c), random_data(), 1'b1, 1'b0);
            read_line("ignored store readback", a);
        end

        // second valid pulse while busy must be dropped
        for (int i = 0; i < 8; i++) begin
            a = addr_t'($urandom());
            send_request("busy poke", 1'b0, a, 4'd3, random_data(), 1'b1, 1'b1);
            read_line("busy poke readback", a);
        end

        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : perfect_memory_tb

//--- verilog/perfect_memory.sv
// fixed-latency simulation memory for processor tests, one request at a time
// the caller holds its request until ready, load data follows one edge later

module perfect_memory #(
    parameter int LINES = 2048,
    parameter int DELAY = 3
) (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  perfect_mem_pkg::addr_t addr_i,
    input  logic                   valid_i,
    input  logic                   wr_ena_i,
    input  perfect_mem_pkg::data_t wr_data_i,
    input  perfect_mem_pkg::size_e word_size_i,
    output perfect_mem_pkg::data_t rdata_o,
    output logic                   ready_o
);
    import perfect_mem_pkg::*;

    mem_req_t  req;
    rd_stage_t rd_stage;
    logic      accept;

    mem_req_decode u_decode (
        .addr_i      (addr_i),
        .wr_ena_i    (wr_ena_i),
        .wr_data_i   (wr_data_i),
        .word_size_i (word_size_i),
        .req_o       (req)
    );

    access_timer #(
        .DELAY (DELAY)
    ) u_timer (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .valid_i  (valid_i),
        .ready_o  (ready_o),
        .accept_o (accept)
    );

    mem_line_store #(
        .LINES (LINES)
    ) u_store (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .accept_i (accept),
        .req_i    (req),
        .rd_o     (rd_stage)
    );

    load_align u_align (
        .rd_i    (rd_stage),
        .rdata_o (rdata_o)
    );

endmodule : perfect_memory

//--- verilog/load_align.sv
// picks the aligned lane out of the captured line and extends it to 64 bits
// invalid size codes read as zero

module load_align (
    input  perfect_mem_pkg::rd_stage_t rd_i,
    output perfect_mem_pkg::data_t     rdata_o
);
    import perfect_mem_pkg::*;

    logic [7:0]        lane_b;
    logic [15:0]       lane_h;
    logic [31:0]       lane_w;
    logic [DATA_W-1:0] lane_d;

    // low offset bits below the access size are dropped
    assign lane_b = rd_i.line[{rd_i.ofs, 3'b000} +: 8];
    assign lane_h = rd_i.line[{rd_i.ofs[OFS_W-1:1], 4'b0000} +: 16];
    assign lane_w = rd_i.line[{rd_i.ofs[OFS_W-1:2], 5'b00000} +: 32];
    assign lane_d = rd_i.line[{rd_i.ofs[OFS_W-1], 6'b000000} +: DATA_W];

    always_comb begin
        case (rd_i.size)
            SZ_B: begin
                rdata_o = {{(DATA_W-8){lane_b[7]}}, lane_b};
            end
            SZ_H: begin
                rdata_o = {{(DATA_W-16){lane_h[15]}}, lane_h};
            end
            SZ_W: begin
                rdata_o = {{(DATA_W-32){lane_w[31]}}, lane_w};
            end
            SZ_D: begin
                rdata_o = lane_d;
            end
            SZ_BU: begin
                rdata_o = {{(DATA_W-8){1'b0}}, lane_b};
            end
            SZ_HU: begin
                rdata_o = {{(DATA_W-16){1'b0}}, lane_h};
            end
            SZ_WU: begin
                rdata_o = {{(DATA_W-32){1'b0}}, lane_w};
            end
            default: begin
                rdata_o = '0;
            end
        endcase
    end

endmodule : load_align

//--- verilog/mem_line_store.sv
// line array with byte-masked stores and a registered read stage
// LINES must be at least 2, contents are undefined until written

module mem_line_store #(
    parameter int LINES = 2048
) (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       accept_i,
    input  perfect_mem_pkg::mem_req_t  req_i,
    output perfect_mem_pkg::rd_stage_t rd_o
);
    import perfect_mem_pkg::*;

    localparam int IDX_W = $clog2(LINES);

    line_t            mem [LINES];
    logic [IDX_W-1:0] line_idx;

    // line number wraps around the storage depth
    assign line_idx = IDX_W'((req_i.addr >> OFS_W) % LINES);

    always_ff @(posedge clk_i) begin
        if (accept_i && req_i.wr) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (req_i.wmask[b]) begin
                    mem[line_idx][b*8 +: 8] <= req_i.wdata_line[b*8 +: 8];
                end
            end
        end
    end

    // captures the line before a store of the same request lands
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rd_o <= '0;
        end else if (accept_i) begin
            rd_o.line <= mem[line_idx];
            rd_o.ofs  <= req_i.addr[OFS_W-1:0];
            rd_o.size <= req_i.size;
        end
    end

endmodule : mem_line_store

//--- verilog/access_timer.sv
// fixed access delay, DELAY must be at least 1
// ready drops for DELAY cycles after every accepted request

module access_timer #(
    parameter int DELAY = 3
) (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic valid_i,
    output logic ready_o,
    output logic accept_o
);
    localparam int CNT_W = $clog2(DELAY + 1);

    logic [CNT_W-1:0] counter;

    assign ready_o  = (counter == '0);
    assign accept_o = valid_i && ready_o;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            counter <= '0;
        end else if (accept_o) begin
            counter <= CNT_W'(DELAY);
        end else if (!ready_o) begin
            counter <= counter - 1'b1;
        end
    end

endmodule : access_timer

//--- verilog/mem_req_decode.sv
// combinational request decode, misaligned offset bits below the size are ignored
// stores with codes 4 to 15 get an empty byte mask and write nothing

module mem_req_decode (
    input  perfect_mem_pkg::addr_t    addr_i,
    input  logic                      wr_ena_i,
    input  perfect_mem_pkg::data_t    wr_data_i,
    input  perfect_mem_pkg::size_e    word_size_i,
    output perfect_mem_pkg::mem_req_t req_o
);
    import perfect_mem_pkg::*;

    logic [OFS_W-1:0]      ofs;
    logic [LINE_BYTES-1:0] mask;
    line_t                 wdata_line;

    assign ofs = addr_i[OFS_W-1:0];

    always_comb begin
        case (word_size_i)
            SZ_B: begin
                mask       = LINE_BYTES'(1) << ofs;
                wdata_line = {(LINE_W/8){wr_data_i[7:0]}};
            end
            SZ_H: begin
                mask       = LINE_BYTES'(2'b11) << {ofs[OFS_W-1:1], 1'b0};
                wdata_line = {(LINE_W/16){wr_data_i[15:0]}};
            end
            SZ_W: begin
                mask       = LINE_BYTES'(4'hf) << {ofs[OFS_W-1:2], 2'b00};
                wdata_line = {(LINE_W/32){wr_data_i[31:0]}};
            end
            SZ_D: begin
                mask       = LINE_BYTES'(8'hff) << {ofs[OFS_W-1], 3'b000};
                wdata_line = {(LINE_W/DATA_W){wr_data_i}};
            end
            default: begin
                // unsigned and invalid codes have no store form
                mask       = '0;
                wdata_line = {(LINE_W/DATA_W){wr_data_i}};
            end
        endcase
    end

    always_comb begin
        req_o.addr       = addr_i;
        req_o.size       = word_size_i;
        req_o.wr         = wr_ena_i;
        req_o.wdata_line = wdata_line;
        req_o.wmask      = mask;
    end

endmodule : mem_req_decode

//--- verilog/perfect_mem_pkg.sv
// shared widths, access size codes and stage structs for the simulation memory
// storage is organised as 128-bit lines, loads and stores carry 64-bit data

package perfect_mem_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 64;
    localparam int LINE_W     = 128;
    localparam int LINE_BYTES = LINE_W / 8;
    localparam int OFS_W      = $clog2(LINE_BYTES);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [LINE_W-1:0] line_t;

    // codes 7 to 15 are invalid
    typedef enum logic [3:0] {
        SZ_B  = 4'd0,
        SZ_H  = 4'd1,
        SZ_W  = 4'd2,
        SZ_D  = 4'd3,
        SZ_BU = 4'd4,
        SZ_HU = 4'd5,
        SZ_WU = 4'd6
    } size_e;

    // decoded request, store data already replicated over every lane
    typedef struct packed {
        addr_t                 addr;
        size_e                 size;
        logic                  wr;
        line_t                 wdata_line;
        logic [LINE_BYTES-1:0] wmask;
    } mem_req_t;

    // registered read stage handed to the load aligner
    typedef struct packed {
        line_t            line;
        logic [OFS_W-1:0] ofs;
        size_e            size;
    } rd_stage_t;

endpackage : perfect_mem_pkg
